/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := calc_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard src/*.sv src/*.svh dv/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/calc_tb.sv */
`timescale 1ns/1ps

module calc_tb;

    localparam int scan_div    = 4;
    localparam int n_tests     = 50;
    localparam int mul_limit   = 10;   // worst multiply from start to done
    localparam int div_latency = 130;  // worst divide from start to done
    localparam int div_limit   = 200;

    logic                clk, reset, start, clear, divide, done;
    arith_pkg::operand_t a, b;
    arith_pkg::result_u  result;
    display_pkg::seg_t   seg;
    display_pkg::anode_t an;
    int                  errors = 0;
    logic [31:0]         lcg_state = 32'hd7f7b556;

    tb_clock #(.period(20), .reset_cycles(8)) clock_gen (.clk(clk), .reset(reset));

    calc_top #(.scan_div(scan_div)) dut0 (
        .clk(clk), .reset(reset), .start(start), .clear(clear), .divide(divide),
        .a(a), .b(b), .result(result), .done(done), .seg(seg), .an(an)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int magnitude_of(input arith_pkg::operand_t x);
        return (x < 0) ? -int'(x) : int'(x);
    endfunction

    // active low with segment a in bit 6 down to g in bit 0
    function automatic display_pkg::seg_t digit_segments(input int d);
        case (d)
            0: return 7'b0000001;
            1: return 7'b1001111;
            2: return 7'b0010010;
            3: return 7'b0000110;
            4: return 7'b1001100;
            5: return 7'b0100100;
            6: return 7'b0100000;
            7: return 7'b0001111;
            8: return 7'b0000000;
            9: return 7'b0000100;
            default: return 7'b1111111;
        endcase
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] expected,
                            input string msg);
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t: %s, got %0d expected %0d", $time, msg, got, expected);
        end
    endtask

    task automatic pulse_start(input arith_pkg::operand_t op_a, input arith_pkg::operand_t op_b,
                               input logic div);
        @(posedge clk);
        a      <= op_a;
        b      <= op_b;
        divide <= div;
        start  <= 1'b1;
        @(posedge clk);
        start  <= 1'b0;  // this edge is the one that takes the start
    endtask

    task automatic wait_done(output int cycles);
        cycles = 0;
        while (cycles < div_limit) begin
            @(negedge clk);
            cycles++;
            if (done)
                break;
        end
        if (!done) begin
            errors++;
            $display("done never rose within %0d cycles at %0t", div_limit, $time);
        end
    endtask

    // eight scan steps from the sign digit against the shown value
    task automatic check_display(input int shown, input logic neg);
        int                  val;
        int                  n;
        display_pkg::seg_t   want;
        display_pkg::anode_t want_an;
        val = shown % 1000;
        n = 0;
        while (an != 4'b1110 && n < 8 * scan_div) begin
            @(negedge clk);
            n++;
        end
        while (an != 4'b0111 && n < 8 * scan_div) begin
            @(negedge clk);
            n++;
        end
        if (an != 4'b0111) begin
            errors++;
            $display("display never reached the sign digit at %0t", $time);
        end
        for (int step = 0; step < 8; step++) begin
            case (step % 4)
                0: want = neg ? 7'b1111110 : 7'b1111111;
                1: want = digit_segments(val / 100);
                2: want = digit_segments((val / 10) % 10);
                default: want = digit_segments(val % 10);
            endcase
            want_an = ~(4'b1000 >> (step % 4));
            check_eq(32'(an), 32'(want_an), "digit select");
            check_eq(32'(seg), 32'(want), "segments");
            repeat (scan_div) @(negedge clk);
        end
    endtask

    task automatic multiply_case(input arith_pkg::operand_t op_a, input arith_pkg::operand_t op_b);
        int cycles;
        int product;
        product = magnitude_of(op_a) * magnitude_of(op_b);
        pulse_start(op_a, op_b, 1'b0);
        wait_done(cycles);
        check_eq(32'(cycles <= mul_limit), 1, "multiply latency");
        check_eq(32'(result.product), 32'(product), "product");
        check_display(product, op_a[7] ^ op_b[7]);
    endtask

    task automatic divide_case(input arith_pkg::operand_t op_a, input arith_pkg::operand_t op_b);
        int cycles;
        int ma;
        int mb;
        ma = magnitude_of(op_a);
        mb = magnitude_of(op_b);
        pulse_start(op_a, op_b, 1'b1);
        wait_done(cycles);
        check_eq(32'(cycles <= div_latency), 1, "divide latency");
        check_eq(32'(result.div.quo), (mb == 0) ? 0 : ma / mb, "quotient");
        check_eq(32'(result.div.rem), (mb == 0) ? ma : ma % mb, "remainder");
    endtask

    task automatic clear_while_busy();
        int cycles;
        pulse_start(8'h80, 8'h01, 1'b1);  // 128 subtract steps
        repeat (10) @(posedge clk);
        pulse_start(8'h07, 8'h02, 1'b0);  // busy so not taken
        wait_done(cycles);
        check_eq(32'(result.div.quo), 128, "quotient after ignored start");
        check_eq(32'(result.div.rem), 0, "remainder after ignored start");
        check_display(128, 1'b1);
        pulse_start(8'h7f, 8'hff, 1'b1);
        repeat (20) @(posedge clk);
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        @(negedge clk);
        check_eq(32'(result), 0, "result after clear");
        // past the point where the aborted division would have finished
        repeat (div_latency) @(negedge clk);
        check_eq(32'(done), 0, "done after clear");
        check_eq(32'(result), 0, "result long after clear");
        check_display(0, 1'b0);
    endtask

    initial begin
        arith_pkg::operand_t corners [5];
        arith_pkg::operand_t ra, rb;
        logic [31:0]         r;
        corners = '{8'h00, 8'h01, 8'hff, 8'h80, 8'h7f};
        start  = 1'b0;
        clear  = 1'b0;
        divide = 1'b0;
        a      = '0;
        b      = '0;
        @(negedge reset);
        @(negedge clk);
        check_eq(32'(done), 0, "done after reset");
        check_eq(32'(an), 32'(4'b0111), "digit select after reset");
        foreach (corners[i])
            foreach (corners[j])
                multiply_case(corners[i], corners[j]);
        for (int k = 0; k < 10; k++) begin
            r = next_random();
            multiply_case(r[15:8], r[23:16]);
        end
        for (int k = 0; k < 10; k++) begin
            r  = next_random();
            ra = r[15:8];
            rb = (r[23:16] == 8'h00) ? 8'h03 : r[23:16];
            divide_case(ra, rb);
        end
        divide_case(8'h9c, 8'h00);  // -100 over zero
        divide_case(8'h2a, 8'h00);
        clear_while_busy();
        repeat (2) @(posedge clk);
        $display("tests finished, error count %0d", errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial begin
        #((n_tests * 200 + 500) * 20);
        $display("timeout, the tests did not finish in time, error count %0d", errors);
        $display("Errors found");
        $finish;
    end

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int period       = 20,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;  // released on an edge, like any other input
    end

endmodule

/* project.f */
+incdir+src
src/arith_pkg.sv
src/display_pkg.sv
src/result_if.sv
src/arith_core.sv
src/bin_to_bcd.sv
src/display_scan.sv
src/calc_top.sv
dv/tb_clock.sv
dv/calc_tb.sv

/* src/arith_core.sv */
`timescale 1ns/1ps
`include "calc_defines.svh"

module arith_core (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic               clear,
    input  logic               divide,
    input  arith_pkg::operand_t a,
    input  arith_pkg::operand_t b,
    result_if.producer         res
);

    logic                 busy;
    logic                 accept;
    logic [`RESULT_W-1:0] mcand;  // multiplicand shifted left each step
    arith_pkg::mag_t      b_mag;  // multiplier in mul mode or divisor in div mode

    function automatic arith_pkg::mag_t magnitude(input arith_pkg::operand_t x);
        return x[`OPERAND_W-1] ? arith_pkg::mag_t'(-x) : arith_pkg::mag_t'(x);
    endfunction

    assign accept = start && !busy && !clear;  // clear wins over start

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy         <= 1'b0;
            res.done     <= 1'b0;
            res.value    <= '0;
            res.op       <= arith_pkg::op_mul;
            res.negative <= 1'b0;
        end else if (clear) begin
            busy      <= 1'b0;
            res.done  <= 1'b0;
            res.value <= '0;
        end else if (accept) begin
            busy         <= 1'b1;
            res.done     <= 1'b0;
            res.op       <= divide ? arith_pkg::op_div : arith_pkg::op_mul;
            res.negative <= a[`OPERAND_W-1] ^ b[`OPERAND_W-1];
            if (divide) begin
                res.value.div.rem <= magnitude(a);  // remainder starts as |a|
                res.value.div.quo <= '0;
            end else begin
                res.value.product <= '0;
            end
        end else if (busy) begin
            if (res.op == arith_pkg::op_mul) begin
                if (b_mag != '0) begin
                    if (b_mag[0])
                        res.value.product <= res.value.product + mcand;
                end else begin
                    busy     <= 1'b0;  // multiplier used up
                    res.done <= 1'b1;
                end
            end else begin
                // zero divisor falls straight through to done
                if (b_mag != '0 && res.value.div.rem >= b_mag) begin
                    res.value.div.rem <= res.value.div.rem - b_mag;
                    res.value.div.quo <= res.value.div.quo + 1'b1;
                end else begin
                    busy     <= 1'b0;
                    res.done <= 1'b1;
                end
            end
        end
    end

    // operand datapath
    always_ff @(posedge clk) begin
        if (accept) begin
            mcand <= `RESULT_W'(magnitude(a));
            b_mag <= magnitude(b);
        end else if (busy && res.op == arith_pkg::op_mul && b_mag != '0) begin
            mcand <= mcand << 1;
            b_mag <= b_mag >> 1;
        end
    end

    // done only rises as a busy run ends and so never on the edge that takes a start
    a_no_done_after_accept: assert property (
        @(posedge clk) disable iff (reset)
        $rose(res.done) |-> $past(busy)
    );

    a_quo_monotonic: assert property (
        @(posedge clk) disable iff (reset)
        (busy && !clear && res.op == arith_pkg::op_div) |=>
            (res.value.div.quo == $past(res.value.div.quo) ||
             res.value.div.quo == $past(res.value.div.quo) + 8'd1)
    );

endmodule

/* src/arith_pkg.sv */
`include "calc_defines.svh"

package arith_pkg;

    typedef enum logic {
        op_mul,  // shift-and-add multiply
        op_div   // repeated-subtraction divide
    } op_e;

    typedef logic signed [`OPERAND_W-1:0] operand_t;

    // unsigned magnitude, holds 128 for an operand of -128
    typedef logic [`OPERAND_W-1:0] mag_t;

    typedef struct packed {
        mag_t rem;  // upper byte
        mag_t quo;  // lower byte
    } div_view_t;

    // one result word, read as a product or as remainder and quotient
    typedef union packed {
        logic [`RESULT_W-1:0] product;
        div_view_t            div;
    } result_u;

endpackage

/* src/bin_to_bcd.sv */
`timescale 1ns/1ps
`include "calc_defines.svh"

module bin_to_bcd (
    input  logic [`RESULT_W-1:0] bin,
    output display_pkg::bcd_t    ones,
    output display_pkg::bcd_t    tens,
    output display_pkg::bcd_t    hundreds
);

    // 65535 needs five decimal digits
    localparam int digits = 5;

    // bcd digits sit above the binary bits and grow as the word shifts in
    logic [`RESULT_W+4*digits-1:0] scratch;

    always_comb begin
        scratch                 = '0;
        scratch[`RESULT_W-1:0] = bin;
        for (int i = 0; i < `RESULT_W; i++) begin
            // add three to any digit of five or more before it doubles
            for (int d = 0; d < digits; d++) begin
                if (scratch[`RESULT_W+4*d +: 4] >= 4'd5)
                    scratch[`RESULT_W+4*d +: 4] = scratch[`RESULT_W+4*d +: 4] + 4'd3;
            end
            scratch = scratch << 1;
        end
    end

    // thousands and ten-thousands are dropped, display shows value mod 1000
    assign ones     = scratch[`RESULT_W +: 4];
    assign tens     = scratch[`RESULT_W+4 +: 4];
    assign hundreds = scratch[`RESULT_W+8 +: 4];

endmodule

/* src/calc_defines.svh */
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// two's-complement operand width, both a and b
`define OPERAND_W 8

// result word, big enough for the full magnitude product
`define RESULT_W 16

// clocks spent on each display digit before moving to the next one
`define SCAN_DIV_DEFAULT 50000

`endif

/* src/calc_top.sv */
`timescale 1ns/1ps
`include "calc_defines.svh"

module calc_top #(
    parameter int scan_div = `SCAN_DIV_DEFAULT
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                clear,
    input  logic                divide,
    input  arith_pkg::operand_t a,
    input  arith_pkg::operand_t b,
    output arith_pkg::result_u  result,
    output logic                done,
    output display_pkg::seg_t   seg,
    output display_pkg::anode_t an
);

    result_if res_bus ();

    arith_core u_core (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .clear  (clear),
        .divide (divide),
        .a      (a),
        .b      (b),
        .res    (res_bus.producer)
    );

    display_scan #(
        .scan_div (scan_div)
    ) u_display (
        .clk   (clk),
        .reset (reset),
        .res   (res_bus.consumer),
        .seg   (seg),
        .an    (an)
    );

    // result word and done also leave the chip directly
    assign result = res_bus.value;
    assign done   = res_bus.done;

endmodule

/* src/display_pkg.sv */
package display_pkg;

    typedef logic [3:0] bcd_t;  // one decimal digit, 0 to 9

    // active low, bit 6 is segment a down to bit 0 for segment g
    typedef logic [6:0] seg_t;

    // active low, bit 3 is the leftmost digit
    typedef logic [3:0] anode_t;

    // only segment g lit
    localparam seg_t seg_minus = 7'b1111110;
    localparam seg_t seg_blank = 7'b1111111;

endpackage

/* src/display_scan.sv */
`timescale 1ns/1ps
`include "calc_defines.svh"

module display_scan #(
    parameter int scan_div = `SCAN_DIV_DEFAULT
) (
    input  logic                clk,
    input  logic                reset,
    result_if.consumer          res,
    output display_pkg::seg_t   seg,
    output display_pkg::anode_t an
);

    localparam int cnt_w = (scan_div > 1) ? $clog2(scan_div) : 1;

    logic [cnt_w-1:0]     div_cnt;
    logic                 tick;
    logic [1:0]           idx;    // 0 sign, 1 hundreds, 2 tens, 3 ones
    logic [`RESULT_W-1:0] shown;
    display_pkg::bcd_t    ones, tens, hundreds;
    display_pkg::seg_t    sign_seg;

    function automatic display_pkg::seg_t seg_decode(input display_pkg::bcd_t d);
        case (d)
            4'd0:    return 7'b0000001;
            4'd1:    return 7'b1001111;
            4'd2:    return 7'b0010010;
            4'd3:    return 7'b0000110;
            4'd4:    return 7'b1001100;
            4'd5:    return 7'b0100100;
            4'd6:    return 7'b0100000;
            4'd7:    return 7'b0001111;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0000100;
            default: return display_pkg::seg_blank;
        endcase
    endfunction

    always_comb begin
        if (!res.done)
            shown = '0;  // nothing valid yet
        else if (res.op == arith_pkg::op_mul)
            shown = res.value.product;
        else
            shown = `RESULT_W'(res.value.div.quo);
    end

    assign sign_seg = (res.done && res.negative) ? display_pkg::seg_minus
                                                 : display_pkg::seg_blank;

    bin_to_bcd u_bcd (
        .bin      (shown),
        .ones     (ones),
        .tens     (tens),
        .hundreds (hundreds)
    );

    assign tick = (div_cnt == cnt_w'(scan_div - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
            idx     <= 2'd0;
        end else if (tick) begin
            div_cnt <= '0;
            idx     <= idx + 2'd1;  // wraps back to the sign digit
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // an and seg refresh every clock from the current index
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            an  <= 4'b0111;
            seg <= display_pkg::seg_blank;
        end else begin
            case (idx)
                2'd0: begin
                    an  <= 4'b0111;
                    seg <= sign_seg;
                end
                2'd1: begin
                    an  <= 4'b1011;
                    seg <= seg_decode(hundreds);
                end
                2'd2: begin
                    an  <= 4'b1101;
                    seg <= seg_decode(tens);
                end
                default: begin
                    an  <= 4'b1110;
                    seg <= seg_decode(ones);
                end
            endcase
        end
    end

    a_one_digit_on: assert property (
        @(posedge clk) disable iff (reset)
        $onehot(~an)
    );

endmodule

/* src/result_if.sv */
`timescale 1ns/1ps

interface result_if;

    arith_pkg::result_u value;     // decode depends on op
    arith_pkg::op_e     op;
    logic               negative;  // operand signs differ
    logic               done;

    modport producer (output value, output op, output negative, output done);
    modport consumer (input value, input op, input negative, input done);

endinterface
